// File: sources.f
logic/bcache_pkg.sv
logic/bcache_line_store.sv
logic/bcache_fill_arbiter.sv
logic/bcache_block_rom.sv
logic/bcache_top.sv
dv/bcache_tb.sv

// File: Bender.yml
package:
  name: bcache

sources:
  - logic/bcache_pkg.sv
  - logic/bcache_line_store.sv
  - logic/bcache_fill_arbiter.sv
  - logic/bcache_block_rom.sv
  - logic/bcache_top.sv
  - target: test
    files:
      - dv/bcache_tb.sv

// File: dv/bcache_tb.sv
`default_nettype none

module bcache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NC             = bcache_pkg::NUM_CLIENTS;
  localparam int AW             = bcache_pkg::ADDR_W;
  localparam int DW             = bcache_pkg::DATA_W;
  localparam int TIMEOUT_CYCLES = 50;
  localparam int RANDOM_REQS    = 300;

  logic                   clk;
  logic                   rst;
  logic [NC-1:0]          req_valid;
  logic [NC-1:0][AW-1:0]  req_addr;
  logic [NC-1:0]          req_ready;
  logic [NC-1:0][DW-1:0]  rd_data;

  int    errors;
  int    test_errors;
  int    tests_run;
  int    tests_failed;
  int    completed;
  bit    timed_out;
  string test_name;

  bcache_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_ready (req_ready),
    .rd_data   (rd_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // memory contents: low byte of the word address times 9d, plus 5b, modulo 256
  function automatic logic [DW-1:0] expected_word(input logic [AW-1:0] addr);
    int unsigned v;
    v = int'(addr[7:0]) * 32'h9d + 32'h5b;
    return DW'(v % 256);
  endfunction

  // called and returns 1 ns after a rising edge
  task automatic access(input int c, input logic [AW-1:0] addr, output logic [DW-1:0] data,
                        output bit ok);
    int waited;
    waited = 0;
    ok     = 1'b1;
    data   = '0;
    req_valid[c] = 1'b1;
    req_addr[c]  = addr;
    @(negedge clk);
    while (!req_ready[c] && ok)
    begin
      if (waited >= TIMEOUT_CYCLES)
      begin
        $display("timeout: client %0d got no req_ready for address %h within %0d cycles in %s",
                 c, addr, TIMEOUT_CYCLES, test_name);
        ok = 1'b0;
        timed_out = 1'b1;
        test_errors++;
      end
      else
      begin
        waited++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
    req_valid[c] = 1'b0;
    if (ok)
    begin
      // word is valid in the cycle after the accept
      @(negedge clk);
      data = rd_data[c];
      completed++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input int c, input logic [AW-1:0] addr, input logic [DW-1:0] got);
    logic [DW-1:0] exp;
    exp = expected_word(addr);
    if (got !== exp)
    begin
      $display("[ERROR] %s: client %0d addr %h expected %h actual %h",
               test_name, c, addr, exp, got);
      test_errors++;
    end
  endtask

  task automatic access_and_check(input int c, input logic [AW-1:0] addr);
    logic [DW-1:0] data;
    bit            ok;
    access(c, addr, data, ok);
    if (ok)
    begin
      check_word(c, addr, data);
    end
  endtask

  // a request in the very next cycle is answered at once only if the first was a hit
  task automatic check_hit_pair(input int c, input logic [AW-1:0] a0, input logic [AW-1:0] a1);
    req_valid[c] = 1'b1;
    req_addr[c]  = a0;
    for (int k = 0; k < 3; k++)
    begin
      @(negedge clk);
      if (k < 2 && req_ready[c] !== 1'b1)
      begin
        $display("[ERROR] %s: req_ready expected 1 actual %b", test_name, req_ready[c]);
        test_errors++;
      end
      if (k > 0)
      begin
        check_word(c, (k == 1) ? a0 : a1, rd_data[c]);
      end
      @(posedge clk);
      #1;
      req_valid[c] = (k == 0);
      req_addr[c]  = a1;
    end
  endtask

  // small window: 16 blocks over 8 lines, so conflicts and shared blocks are common
  task automatic random_client(input int c);
    logic [AW-1:0] addr;
    for (int n = 0; n < RANDOM_REQS && !timed_out; n++)
    begin
      addr = 16'h0200 + AW'($urandom_range(63, 0));
      access_and_check(c, addr);
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0)
    begin
      $display("%s: ok", test_name);
    end
    else
    begin
      $display("%s: failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  initial
  begin
    void'($urandom(32'h2922_3d1f));
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    completed    = 0;
    timed_out    = 1'b0;
    rst          = 1'b1;
    req_valid    = '0;
    req_addr     = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "reset_idle";
    for (int k = 0; k < 5; k++)
    begin
      @(negedge clk);
      if (req_ready !== '0)
      begin
        $display("[ERROR] %s: req_ready expected %b actual %b", test_name, NC'(0), req_ready);
        test_errors++;
      end
    end
    @(posedge clk);
    #1;
    access_and_check(0, 16'h0104);
    finish_test();

    if (!timed_out)
    begin
      test_name = "repeat_hit";
      check_hit_pair(0, 16'h0104, 16'h0105);
      check_hit_pair(0, 16'h0105, 16'h0104);
      finish_test();
    end

    if (!timed_out)
    begin
      // 0124 and 0144 share line 1 with different tags
      test_name = "tag_replace";
      for (int k = 0; k < 6; k++)
      begin
        access_and_check(1, (k % 2 == 0) ? 16'h0124 : 16'h0144);
      end
      finish_test();
    end

    if (!timed_out)
    begin
      test_name = "shared_block";
      for (int c = 0; c < NC; c++)
      begin
        fork
          automatic int cc = c;
          access_and_check(cc, 16'h3a40 + AW'(cc));
        join_none
      end
      wait fork;
      finish_test();
    end

    if (!timed_out)
    begin
      test_name = "random_traffic";
      completed = 0;
      for (int c = 0; c < NC; c++)
      begin
        fork
          automatic int cc = c;
          random_client(cc);
        join_none
      end
      wait fork;
      if (completed != NC * RANDOM_REQS)
      begin
        $display("[ERROR] %s: completed requests expected %0d actual %0d",
                 test_name, NC * RANDOM_REQS, completed);
        test_errors++;
      end
      finish_test();
    end

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/bcache_top.sv
`default_nettype none

module bcache_top (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  logic [bcache_pkg::NUM_CLIENTS-1:0]                      req_valid,
  input  logic [bcache_pkg::NUM_CLIENTS-1:0][bcache_pkg::ADDR_W-1:0] req_addr,
  output logic [bcache_pkg::NUM_CLIENTS-1:0]                      req_ready,
  output logic [bcache_pkg::NUM_CLIENTS-1:0][bcache_pkg::DATA_W-1:0] rd_data
);

  // shared fill path
  logic [bcache_pkg::NUM_CLIENTS-1:0]                            miss_valid;
  logic [bcache_pkg::NUM_CLIENTS-1:0][bcache_pkg::BLOCK_ADDR_W-1:0] miss_addr;
  logic [bcache_pkg::NUM_CLIENTS-1:0]                            grant;
  bcache_pkg::fill_bcast_t                                       bcast;
  bcache_pkg::block_t                                            fill_data;

  for (genvar i = 0; i < bcache_pkg::NUM_CLIENTS; i++)
  begin : g_cache
    bcache_line_store u_cache (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid[i]),
      .req_addr   (req_addr[i]),
      .grant      (grant[i]),
      .bcast      (bcast),
      .fill_data  (fill_data),
      .req_ready  (req_ready[i]),
      .rd_data    (rd_data[i]),
      .miss_valid (miss_valid[i]),
      .miss_addr  (miss_addr[i])
    );
  end

  bcache_fill_arbiter u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .miss_valid (miss_valid),
    .miss_addr  (miss_addr),
    .grant      (grant),
    .bcast      (bcast)
  );

  bcache_block_rom u_rom (
    .clk       (clk),
    .rst       (rst),
    .bcast     (bcast),
    .fill_data (fill_data)
  );

endmodule

`default_nettype wire

// File: logic/bcache_block_rom.sv
`default_nettype none

module bcache_block_rom (
  input  logic                    clk,
  input  logic                    rst,
  input  bcache_pkg::fill_bcast_t bcast,
  output bcache_pkg::block_t      fill_data
);

  // block address of the last granted fetch
  logic [bcache_pkg::BLOCK_ADDR_W-1:0] addr_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q <= '0;
    end
    else if (bcast.valid)
    begin
      addr_q <= bcast.addr;
    end
  end

  // whole block, one word per lane, from the contents rule
  always_comb
  begin
    for (int w = 0; w < bcache_pkg::WORDS_PER_BLOCK; w++)
    begin
      fill_data[w] = bcache_pkg::block_word({addr_q, bcache_pkg::WORD_SEL_W'(w)});
    end
  end

endmodule

`default_nettype wire

// File: logic/bcache_fill_arbiter.sv
`default_nettype none

module bcache_fill_arbiter (
  input  logic                                                          clk,
  input  logic                                                          rst,
  input  logic [bcache_pkg::NUM_CLIENTS-1:0]                            miss_valid,
  input  logic [bcache_pkg::NUM_CLIENTS-1:0][bcache_pkg::BLOCK_ADDR_W-1:0] miss_addr,
  output logic [bcache_pkg::NUM_CLIENTS-1:0]                            grant,
  output bcache_pkg::fill_bcast_t                                       bcast
);

  // client with the highest priority this cycle
  logic [bcache_pkg::CLIENT_IDX_W-1:0] ptr_q;

  logic                                found;
  logic [bcache_pkg::CLIENT_IDX_W-1:0] winner;

  // first missing cache at or after the pointer, wrapping around
  always_comb
  begin
    found  = 1'b0;
    winner = '0;
    for (int k = 0; k < bcache_pkg::NUM_CLIENTS; k++)
    begin
      if (!found && miss_valid[(int'(ptr_q) + k) % bcache_pkg::NUM_CLIENTS])
      begin
        found  = 1'b1;
        winner = bcache_pkg::CLIENT_IDX_W'((int'(ptr_q) + k) % bcache_pkg::NUM_CLIENTS);
      end
    end
  end

  always_comb
  begin
    grant         = '0;
    grant[winner] = found;
  end

  // winner's block goes to the ROM and to every cache
  assign bcast = '{valid: found, addr: miss_addr[winner]};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ptr_q <= '0;
    end
    else if (found)
    begin
      // move past the winner so it has the lowest priority next time
      if (winner == bcache_pkg::CLIENT_IDX_W'(bcache_pkg::NUM_CLIENTS - 1))
      begin
        ptr_q <= '0;
      end
      else
      begin
        ptr_q <= winner + 1'b1;
      end
    end
  end

  grant_onehot0: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  );

endmodule

`default_nettype wire

// File: logic/bcache_line_store.sv
`default_nettype none

module bcache_line_store (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req_valid,
  input  logic [bcache_pkg::ADDR_W-1:0]       req_addr,
  input  logic                                grant,
  input  bcache_pkg::fill_bcast_t             bcast,
  input  bcache_pkg::block_t                  fill_data,
  output logic                                req_ready,
  output logic [bcache_pkg::DATA_W-1:0]       rd_data,
  output logic                                miss_valid,
  output logic [bcache_pkg::BLOCK_ADDR_W-1:0] miss_addr
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_BCAST_FILL
  } state_t;

  state_t state_q;
  state_t state_d;

  // line storage with its tags and presence bits
  logic [bcache_pkg::BLOCK_W-1:0]   content [bcache_pkg::NUM_LINES];
  logic [bcache_pkg::TAG_W-1:0]     tag_mem [bcache_pkg::NUM_LINES];
  logic [bcache_pkg::NUM_LINES-1:0] present;

  // registered line read, gives the one cycle hit latency
  logic [bcache_pkg::BLOCK_W-1:0] line_q;

  // request address fields
  logic [bcache_pkg::WORD_SEL_W-1:0] word_in;
  logic [bcache_pkg::LINE_SEL_W-1:0] line_sel_in;
  logic [bcache_pkg::TAG_W-1:0]      tag_in;

  // broadcast address fields
  logic [bcache_pkg::LINE_SEL_W-1:0] bc_line;
  logic [bcache_pkg::TAG_W-1:0]      bc_tag;

  // fields saved for the fill cycle
  logic [bcache_pkg::WORD_SEL_W-1:0] word_q;
  logic [bcache_pkg::WORD_SEL_W-1:0] word_d;
  logic [bcache_pkg::LINE_SEL_W-1:0] line_sel_q;
  logic [bcache_pkg::LINE_SEL_W-1:0] line_sel_d;
  logic [bcache_pkg::TAG_W-1:0]      tag_q;
  logic [bcache_pkg::TAG_W-1:0]      tag_d;

  logic hit;
  logic need_fill;
  logic fill_ok;

  assign word_in     = req_addr[0 +: bcache_pkg::WORD_SEL_W];
  assign line_sel_in = req_addr[bcache_pkg::WORD_SEL_W +: bcache_pkg::LINE_SEL_W];
  assign tag_in      = req_addr[bcache_pkg::ADDR_W-1 -: bcache_pkg::TAG_W];

  assign bc_line = bcast.addr[0 +: bcache_pkg::LINE_SEL_W];
  assign bc_tag  = bcast.addr[bcache_pkg::BLOCK_ADDR_W-1 -: bcache_pkg::TAG_W];

  // block address of the request, forwarded to the fill path on a miss
  assign miss_addr = req_addr[bcache_pkg::ADDR_W-1 -: bcache_pkg::BLOCK_ADDR_W];

  assign hit       = present[line_sel_in] && (tag_mem[line_sel_in] == tag_in);
  assign need_fill = req_valid && !hit;

  // served either by our own grant or by someone else fetching the same block
  assign fill_ok = grant || (bcast.valid && (bcast.addr == miss_addr));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ST_IDLE;
      present <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q != ST_IDLE)
      begin
        present[line_sel_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    word_q     <= word_d;
    line_sel_q <= line_sel_d;
    tag_q      <= tag_d;
    line_q     <= content[line_sel_in];
    // fill_data belongs to the broadcast of the previous cycle
    if (state_q != ST_IDLE)
    begin
      tag_mem[line_sel_q] <= tag_q;
      content[line_sel_q] <= fill_data;
    end
  end

  always_comb
  begin
    state_d    = state_q;
    word_d     = word_q;
    line_sel_d = line_sel_q;
    tag_d      = tag_q;
    req_ready  = 1'b0;
    miss_valid = 1'b0;
    rd_data    = line_q[word_q*bcache_pkg::DATA_W +: bcache_pkg::DATA_W];

    case (state_q)
      ST_IDLE:
      begin
        word_d     = word_in;
        line_sel_d = line_sel_in;
        tag_d      = tag_in;
        req_ready  = req_valid && hit;
        miss_valid = need_fill;
        if (need_fill && fill_ok)
        begin
          state_d   = ST_FETCH;
          req_ready = 1'b1;
        end
        else if (bcast.valid && !present[bc_line])
        begin
          // prefill an empty line from a block someone else asked for
          line_sel_d = bc_line;
          tag_d      = bc_tag;
          state_d    = ST_BCAST_FILL;
        end
      end
      ST_FETCH:
      begin
        // bypass the store, the line is written at the end of this cycle
        state_d = ST_IDLE;
        rd_data = fill_data[word_q];
      end
      ST_BCAST_FILL:
      begin
        state_d = ST_IDLE;
      end
      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  ready_needs_valid: assert property (
    @(posedge clk) disable iff (rst)
    req_ready |-> req_valid
  );

  miss_only_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    miss_valid |-> (state_q == ST_IDLE)
  );

endmodule

`default_nettype wire

// File: logic/bcache_pkg.sv
`default_nettype none

package bcache_pkg;

  // one direct-mapped cache per basic-block client
  localparam int NUM_CLIENTS  = 3;
  localparam int CLIENT_IDX_W = $clog2(NUM_CLIENTS);

  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  // word address layout is {tag, line, word}
  localparam int WORD_SEL_W      = 2;
  localparam int LINE_SEL_W      = 3;
  localparam int WORDS_PER_BLOCK = 2 ** WORD_SEL_W;
  localparam int NUM_LINES       = 2 ** LINE_SEL_W;
  localparam int BLOCK_ADDR_W    = ADDR_W - WORD_SEL_W;
  localparam int TAG_W           = BLOCK_ADDR_W - LINE_SEL_W;
  localparam int BLOCK_W         = DATA_W * WORDS_PER_BLOCK;

  // coefficients of the memory contents rule
  localparam logic [DATA_W-1:0] ROM_MUL = 8'h9d;
  localparam logic [DATA_W-1:0] ROM_ADD = 8'h5b;

  // block fetch announced to every cache in the grant cycle
  typedef struct packed {
    logic                    valid;
    logic [BLOCK_ADDR_W-1:0] addr;
  } fill_bcast_t;

  // word 0 sits in the lowest bits
  typedef logic [WORDS_PER_BLOCK-1:0][DATA_W-1:0] block_t;

  // contents of the read-only store at one word address
  function automatic logic [DATA_W-1:0] block_word(input logic [ADDR_W-1:0] word_addr);
    logic [DATA_W-1:0] low;
    low = word_addr[DATA_W-1:0];
    return low * ROM_MUL + ROM_ADD;
  endfunction

endpackage

`default_nettype wire
